/* design/avalon_pkg.sv */
package avalon_pkg;

    localparam int LINE_BYTES = 64;  // one system memory line
    localparam int LINE_WORDS = 16;  // 32-bit words per line

    typedef logic [LINE_BYTES*8-1:0] avalon_line_t;

    // master side, single-beat reads only
    typedef struct packed {
        logic [63:0]           address;
        logic                  read;
        logic [2:0]            burstcount;
        logic [LINE_BYTES-1:0] byteenable;
    } avalon_cmd_t;

    // slave side
    typedef struct packed {
        logic         waitrequest;
        logic         readdatavalid;
        avalon_line_t readdata;
    } avalon_rsp_t;

endpackage

/* design/loader_pkg.sv */
package loader_pkg;

    localparam int MAX_CORES  = 16;
    localparam int CORE_W     = $clog2(MAX_CORES);
    localparam int WORD_IDX_W = 32 - 1 - CORE_W;  // tag fills 32 bits

    typedef enum logic [1:0] {
        IDLE,
        FETCH_INSN,
        FETCH_DATA,
        DRAIN
    } load_state_e;

    typedef enum logic {
        SEL_INSN = 1'b0,
        SEL_DATA = 1'b1
    } mem_sel_e;

    typedef struct packed {
        mem_sel_e                sel;
        logic [CORE_W-1:0]       core;
        logic [WORD_IDX_W-1:0]   first;  // word index of word 0 of the line
    } line_tag_t;

    typedef struct packed {
        line_tag_t   tag;
        logic [63:0] addr;
    } line_req_t;

    typedef struct packed {
        line_tag_t               tag;
        avalon_pkg::avalon_line_t data;
    } line_data_t;

    typedef struct packed {
        mem_sel_e              sel;
        logic [CORE_W-1:0]     core;
        logic [WORD_IDX_W-1:0] idx;
        logic [31:0]           data;
    } word_write_t;

endpackage

/* design/load_sequencer.sv */
`timescale 1ns/1ps

module load_sequencer #(
    parameter int CORES      = 4,
    parameter int INSN_DEPTH = 5,
    parameter int DMEM_DEPTH = 6
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     kick,
    input  logic [63:0]              base_addr,
    input  logic [$clog2(CORES)-1:0] target_core,
    output logic                     busy,
    output logic                     req_valid,
    input  logic                     req_ready,
    output loader_pkg::line_req_t    req,
    input  logic                     line_done
);
    import loader_pkg::*;
    import avalon_pkg::*;

    localparam int INSN_LINES  = (2**INSN_DEPTH) / LINE_WORDS;
    localparam int DMEM_LINES  = (2**DMEM_DEPTH) / LINE_WORDS;
    localparam int TOTAL_LINES = INSN_LINES + DMEM_LINES;
    localparam int IW          = $clog2(TOTAL_LINES);
    localparam int DW          = $clog2(TOTAL_LINES + 1);
    localparam int CW          = $clog2(CORES);

    load_state_e    state_q;
    logic           busy_q;
    logic [63:0]    base_q;
    logic [CW-1:0]  core_q;
    logic [IW-1:0]  issue_idx;  // lines issued so far, both images
    logic [DW-1:0]  done_cnt;   // lines fully written
    logic [IW-1:0]  line_idx;
    logic           req_fire;

    assign busy      = busy_q | kick;
    assign req_valid = (state_q == FETCH_INSN) || (state_q == FETCH_DATA);
    assign req_fire  = req_valid && req_ready;

    // index within the selected memory
    assign line_idx = (state_q == FETCH_DATA) ? issue_idx - IW'(INSN_LINES) : issue_idx;

    always_comb begin
        req          = '0;
        req.addr     = base_q + 64'(issue_idx) * 64'(LINE_BYTES);  // data follows insn image
        req.tag.sel  = (state_q == FETCH_DATA) ? SEL_DATA : SEL_INSN;
        req.tag.core = CORE_W'(core_q);
        req.tag.first = WORD_IDX_W'(line_idx) * WORD_IDX_W'(LINE_WORDS);
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && kick) begin
            base_q <= base_addr;
            core_q <= target_core;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= IDLE;
            busy_q    <= 1'b0;
            issue_idx <= '0;
            done_cnt  <= '0;
        end else begin
            if (line_done && state_q != IDLE)
                done_cnt <= done_cnt + 1'b1;
            case (state_q)
                IDLE: begin
                    if (kick) begin  // kick while busy never gets here
                        busy_q    <= 1'b1;
                        issue_idx <= '0;
                        done_cnt  <= '0;
                        state_q   <= FETCH_INSN;
                    end
                end
                FETCH_INSN: begin
                    if (req_fire) begin
                        issue_idx <= issue_idx + 1'b1;
                        if (issue_idx == IW'(INSN_LINES - 1))
                            state_q <= FETCH_DATA;
                    end
                end
                FETCH_DATA: begin
                    if (req_fire) begin
                        issue_idx <= issue_idx + 1'b1;
                        if (issue_idx == IW'(TOTAL_LINES - 1))
                            state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (line_done && done_cnt == DW'(TOTAL_LINES - 1)) begin
                        busy_q  <= 1'b0;  // last data line written
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

/* design/avalon_read_master.sv */
`timescale 1ns/1ps

module avalon_read_master (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  loader_pkg::line_req_t   req,
    output logic                    line_valid,
    input  logic                    line_ready,
    output loader_pkg::line_data_t  line,
    output avalon_pkg::avalon_cmd_t m0_cmd,
    input  avalon_pkg::avalon_rsp_t m0_rsp
);
    import loader_pkg::*;
    import avalon_pkg::*;

    logic         rd_q;    // read strobe on the bus
    logic         pend_q;  // waiting for readdatavalid
    logic         full_q;  // line buffer holds a line
    logic [63:0]  addr_q;
    line_tag_t    tag_q;
    avalon_line_t data_q;

    assign req_ready  = !rd_q && !pend_q && !full_q;
    assign line_valid = full_q;
    assign line.tag   = tag_q;
    assign line.data  = data_q;

    assign m0_cmd.address    = addr_q;
    assign m0_cmd.read       = rd_q;
    assign m0_cmd.burstcount = 3'd1;
    assign m0_cmd.byteenable = '1;

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            addr_q <= req.addr;
            tag_q  <= req.tag;  // follows the line to the unpacker
        end
        if (pend_q && m0_rsp.readdatavalid)
            data_q <= m0_rsp.readdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q   <= 1'b0;
            pend_q <= 1'b0;
            full_q <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                rd_q   <= 1'b1;
                pend_q <= 1'b1;
            end else if (rd_q && !m0_rsp.waitrequest) begin
                rd_q <= 1'b0;  // command accepted
            end
            if (pend_q && m0_rsp.readdatavalid) begin
                pend_q <= 1'b0;
                full_q <= 1'b1;
            end else if (line_valid && line_ready) begin
                full_q <= 1'b0;
            end
        end
    end

    // slave must see a steady command until it stops stalling
    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        m0_cmd.read && m0_rsp.waitrequest |=> m0_cmd.read && $stable(m0_cmd.address));

    // no unsolicited read data from the slave
    a_no_stray_rdv: assert property (@(posedge clk) disable iff (reset)
        m0_rsp.readdatavalid |-> pend_q);

endmodule

/* design/line_unpacker.sv */
`timescale 1ns/1ps

module line_unpacker #(
    parameter int CORES = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    line_valid,
    output logic                    line_ready,
    input  loader_pkg::line_data_t  line,
    output logic                    wr_valid,
    output loader_pkg::word_write_t wr,
    output logic                    line_done
);
    import loader_pkg::*;
    import avalon_pkg::*;

    avalon_line_t shift_q;
    line_tag_t    tag_q;
    logic [3:0]   cnt_q;
    logic         active_q;

    assign line_ready = !active_q;
    assign wr_valid   = active_q;
    assign line_done  = active_q && (cnt_q == 4'(LINE_WORDS - 1));

    assign wr.sel  = tag_q.sel;
    assign wr.core = tag_q.core;
    assign wr.idx  = tag_q.first + WORD_IDX_W'(cnt_q);
    assign wr.data = shift_q[31:0];  // lowest word goes first

    always_ff @(posedge clk) begin
        if (line_valid && line_ready) begin
            shift_q <= line.data;
            tag_q   <= line.tag;
        end else if (active_q) begin
            shift_q <= shift_q >> 32;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else begin
            if (line_valid && line_ready) begin
                active_q <= 1'b1;
                cnt_q    <= '0;
            end else if (active_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (line_done)
                    active_q <= 1'b0;
            end
        end
    end

    // once taken, a line blocks the input for its whole drain
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        line_valid && line_ready |=> (!line_ready) [*LINE_WORDS]);

    // tags from the sequencer only name cores that exist
    a_core_range: assert property (@(posedge clk) disable iff (reset)
        line_valid |-> int'(line.tag.core) < CORES);

endmodule

/* design/core_mem_bank.sv */
`timescale 1ns/1ps

module core_mem_bank #(
    parameter int CORES      = 4,
    parameter int INSN_DEPTH = 5,
    parameter int DMEM_DEPTH = 6
) (
    input  logic                     clk,
    input  logic                     wr_valid,
    input  loader_pkg::word_write_t  wr,
    input  loader_pkg::mem_sel_e     rd_sel,
    input  logic [$clog2(CORES)-1:0] rd_core,
    input  logic [(INSN_DEPTH > DMEM_DEPTH ? INSN_DEPTH : DMEM_DEPTH)-1:0] rd_addr,
    output logic [31:0]              rd_data
);
    import loader_pkg::*;

    localparam int CW         = $clog2(CORES);
    localparam int INSN_WORDS = CORES * (2**INSN_DEPTH);
    localparam int DMEM_WORDS = CORES * (2**DMEM_DEPTH);

    logic [31:0] insn_mem [INSN_WORDS];
    logic [31:0] dmem_mem [DMEM_WORDS];

    logic [CW+INSN_DEPTH-1:0] insn_waddr;
    logic [CW+DMEM_DEPTH-1:0] dmem_waddr;
    logic [CW+INSN_DEPTH-1:0] insn_raddr;
    logic [CW+DMEM_DEPTH-1:0] dmem_raddr;

    // core picks the slice, word index the entry
    assign insn_waddr = {wr.core[CW-1:0], wr.idx[INSN_DEPTH-1:0]};
    assign dmem_waddr = {wr.core[CW-1:0], wr.idx[DMEM_DEPTH-1:0]};
    assign insn_raddr = {rd_core, rd_addr[INSN_DEPTH-1:0]};
    assign dmem_raddr = {rd_core, rd_addr[DMEM_DEPTH-1:0]};

    always_ff @(posedge clk) begin
        if (wr_valid && wr.sel == SEL_INSN)
            insn_mem[insn_waddr] <= wr.data;
    end

    always_ff @(posedge clk) begin
        if (wr_valid && wr.sel == SEL_DATA)
            dmem_mem[dmem_waddr] <= wr.data;
    end

    always_ff @(posedge clk) begin
        if (rd_sel == SEL_INSN)
            rd_data <= insn_mem[insn_raddr];
        else
            rd_data <= dmem_mem[dmem_raddr];  // one cycle after rd_addr
    end

endmodule

/* design/program_loader_top.sv */
`timescale 1ns/1ps

module program_loader_top #(
    parameter int CORES      = 4,
    parameter int INSN_DEPTH = 5,
    parameter int DMEM_DEPTH = 6
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     kick,
    input  logic [63:0]              base_addr,
    input  logic [$clog2(CORES)-1:0] target_core,
    output logic                     busy,
    output avalon_pkg::avalon_cmd_t  m0_cmd,
    input  avalon_pkg::avalon_rsp_t  m0_rsp,
    input  loader_pkg::mem_sel_e     rd_sel,
    input  logic [$clog2(CORES)-1:0] rd_core,
    input  logic [(INSN_DEPTH > DMEM_DEPTH ? INSN_DEPTH : DMEM_DEPTH)-1:0] rd_addr,
    output logic [31:0]              rd_data
);
    import loader_pkg::*;

    logic        req_valid;
    logic        req_ready;
    line_req_t   req;
    logic        line_valid;
    logic        line_ready;
    line_data_t  line;
    logic        wr_valid;
    word_write_t wr;
    logic        line_done;

    load_sequencer #(
        .CORES(CORES), .INSN_DEPTH(INSN_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)
    ) u_seq (
        .clk(clk), .reset(reset),
        .kick(kick), .base_addr(base_addr), .target_core(target_core), .busy(busy),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .line_done(line_done)
    );

    avalon_read_master u_master (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .line_valid(line_valid), .line_ready(line_ready), .line(line),
        .m0_cmd(m0_cmd), .m0_rsp(m0_rsp)
    );

    line_unpacker #(.CORES(CORES)) u_unpack (
        .clk(clk), .reset(reset),
        .line_valid(line_valid), .line_ready(line_ready), .line(line),
        .wr_valid(wr_valid), .wr(wr), .line_done(line_done)
    );

    core_mem_bank #(
        .CORES(CORES), .INSN_DEPTH(INSN_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)
    ) u_bank (
        .clk(clk),
        .wr_valid(wr_valid), .wr(wr),
        .rd_sel(rd_sel), .rd_core(rd_core), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

/* test/avalon_mem_model.sv */
`timescale 1ns/1ps

module avalon_mem_model (
    input  logic                    clk,
    input  logic                    reset,
    input  avalon_pkg::avalon_cmd_t cmd,
    output avalon_pkg::avalon_rsp_t rsp
);
    import avalon_pkg::*;

    localparam logic [15:0] SEED    = 16'd29527;
    localparam logic [31:0] PATTERN = 32'hA5A5_0000;

    logic [15:0]  lfsr_q;
    logic [15:0]  s1, s2, s3, s4;
    logic [1:0]   wait_left;  // stall cycles left for the current command
    logic [2:0]   lat_left;
    logic         pend_q;
    logic         rdv_q;
    logic [63:0]  addr_q;
    avalon_line_t data_q;

    // fibonacci, x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic avalon_line_t line_at(input logic [63:0] addr);
        avalon_line_t l;
        for (int k = 0; k < LINE_WORDS; k++)
            l[32*k +: 32] = 32'(addr + 64'(4*k)) ^ PATTERN;  // byte address of each word
        return l;
    endfunction

    assign s1 = lfsr_step(lfsr_q);  // one step per bit taken
    assign s2 = lfsr_step(s1);
    assign s3 = lfsr_step(s2);
    assign s4 = lfsr_step(s3);

    assign rsp.waitrequest   = cmd.read && (wait_left != 2'd0);
    assign rsp.readdatavalid = rdv_q;
    assign rsp.readdata      = data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr_q    <= SEED;
            wait_left <= 2'd0;
            lat_left  <= 3'd0;
            pend_q    <= 1'b0;
            rdv_q     <= 1'b0;
        end else begin
            rdv_q <= 1'b0;
            if (cmd.read && wait_left != 2'd0) begin
                wait_left <= wait_left - 1'b1;
            end else if (cmd.read) begin
                addr_q    <= cmd.address;
                pend_q    <= 1'b1;
                wait_left <= {s1[0], s2[0]};  // stall for the next command
                lat_left  <= 3'd1 + {1'b0, s3[0], s4[0]};
                lfsr_q    <= s4;
            end
            if (pend_q) begin
                if (lat_left == 3'd1) begin
                    rdv_q  <= 1'b1;
                    data_q <= line_at(addr_q);
                    pend_q <= 1'b0;
                end else begin
                    lat_left <= lat_left - 1'b1;
                end
            end
        end
    end

endmodule

/* test/tb_program_loader.sv */
`timescale 1ns/1ps

module tb_program_loader;
    import avalon_pkg::*;
    import loader_pkg::*;

    localparam int CORES      = 4;
    localparam int INSN_DEPTH = 5;
    localparam int DMEM_DEPTH = 6;
    localparam int CW         = $clog2(CORES);
    localparam int INSN_WORDS = 2**INSN_DEPTH;
    localparam int DMEM_WORDS = 2**DMEM_DEPTH;
    localparam int AW         = (INSN_DEPTH > DMEM_DEPTH) ? INSN_DEPTH : DMEM_DEPTH;
    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROWS   = 4;
    localparam int ROW_CYCLES = 2000;
    localparam logic [31:0] PATTERN = 32'hA5A5_0000;

    typedef struct packed {
        logic [63:0]              base;
        logic [$clog2(CORES)-1:0] core;
        logic                     kick_busy;  // second kick mid-load
    } row_t;

    row_t table_rows [NUM_ROWS] = '{
        '{base: 64'h0000_0000_0000_0000, core: 2'd0, kick_busy: 1'b0},
        '{base: 64'h0000_0010_0000_2000, core: 2'd2, kick_busy: 1'b0},
        '{base: 64'h0000_0000_0003_0c00, core: 2'd1, kick_busy: 1'b1},
        '{base: 64'h0000_0000_ffff_ff00, core: 2'd3, kick_busy: 1'b0}  // carries past bit 31
    };

    logic                     clk;
    logic                     reset;
    logic                     kick;
    logic [63:0]              base_addr;
    logic [$clog2(CORES)-1:0] target_core;
    logic                     busy;
    avalon_cmd_t              m0_cmd;
    avalon_rsp_t              m0_rsp;
    mem_sel_e                 rd_sel;
    logic [$clog2(CORES)-1:0] rd_core;
    logic [AW-1:0]            rd_addr;
    logic [31:0]              rd_data;

    int          word_errs;
    int          busy_errs;
    int          cmd_errs;
    int          other_errs;
    logic [63:0] load_base;  // base of the load in progress
    logic [63:0] exp_base [CORES];
    bit          loaded [CORES];

    program_loader_top #(
        .CORES(CORES), .INSN_DEPTH(INSN_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)
    ) DUT (
        .clk(clk), .reset(reset),
        .kick(kick), .base_addr(base_addr), .target_core(target_core), .busy(busy),
        .m0_cmd(m0_cmd), .m0_rsp(m0_rsp),
        .rd_sel(rd_sel), .rd_core(rd_core), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    avalon_mem_model u_mem (
        .clk(clk), .reset(reset), .cmd(m0_cmd), .rsp(m0_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // data image sits right behind the instruction image
    function automatic logic [31:0] expected_word(input logic [63:0] base, input mem_sel_e sel,
                                                  input int idx);
        int offset;
        offset = (sel == SEL_INSN) ? idx : INSN_WORDS + idx;
        return 32'(base + 64'(4*offset)) ^ PATTERN;
    endfunction

    task automatic check_word(input mem_sel_e sel, input int core, input int idx,
                              input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %0t: %s core %0d word %0d got %h expected %h",
                     $time, sel.name(), core, idx, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH %0t: %s, busy is %b, expected %b", $time, what, got, exp);
            busy_errs++;
        end
    endtask

    // single full-width beat on a line inside the two images
    task automatic check_cmd(input avalon_cmd_t got, input logic [63:0] base);
        logic [63:0] offset;
        offset = got.address - base;
        if (got.burstcount !== 3'd1 || got.byteenable !== '1 ||
            offset >= 64'((INSN_WORDS + DMEM_WORDS) * 4) || offset[5:0] !== 6'd0) begin
            $display("MISMATCH %0t: read at %h burstcount %0d byteenable %h, base %h",
                     $time, got.address, got.burstcount, got.byteenable, base);
            cmd_errs++;
        end
    endtask

    always @(negedge clk) begin
        if (reset === 1'b0 && m0_cmd.read === 1'b1)
            check_cmd(m0_cmd, load_base);
    end

    task automatic read_word(input mem_sel_e sel, input int core, input int idx,
                             output logic [31:0] got);
        @(posedge clk);
        #2;
        rd_sel  = sel;
        rd_core = CW'(core);
        rd_addr = AW'(idx);
        @(posedge clk);
        #1;
        got = rd_data;  // registered read
    endtask

    task automatic check_core(input int core);
        logic [31:0] got;
        for (int i = 0; i < INSN_WORDS; i++) begin
            read_word(SEL_INSN, core, i, got);
            check_word(SEL_INSN, core, i, got, expected_word(exp_base[core], SEL_INSN, i));
        end
        for (int j = 0; j < DMEM_WORDS; j++) begin
            read_word(SEL_DATA, core, j, got);
            check_word(SEL_DATA, core, j, got, expected_word(exp_base[core], SEL_DATA, j));
        end
    endtask

    task automatic run_row(input row_t row);
        time t_kick;
        int  waited;
        int  cycles;
        @(posedge clk);
        #2;
        kick        = 1'b1;
        base_addr   = row.base;
        target_core = row.core;
        load_base   = row.base;
        t_kick      = $time;
        #1 check_busy(busy, 1'b1, "busy in kick cycle");
        @(posedge clk);
        #2 kick = 1'b0;
        #1 check_busy(busy, 1'b1, "busy after kick");
        if (row.kick_busy) begin
            repeat (4) @(posedge clk);
            #2;
            kick        = 1'b1;
            base_addr   = row.base + 64'h4_0000;
            target_core = row.core ^ 2'b11;  // points at another loaded core
            #1 check_busy(busy, 1'b1, "busy during second kick");
            @(posedge clk);
            #2 kick = 1'b0;
        end
        waited = 0;
        while (busy === 1'b1 && waited < ROW_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (busy !== 1'b0) begin
            $display("load to core %0d did not finish, busy still high after %0d cycles",
                     row.core, waited);
            other_errs++;
        end else begin
            cycles = int'(($time - t_kick) / CLK_PERIOD);
            if (cycles < INSN_WORDS + DMEM_WORDS) begin
                $display("busy fell after %0d cycles, too early to write %0d words",
                         cycles, INSN_WORDS + DMEM_WORDS);
                other_errs++;
            end
            @(posedge clk);
            #1 check_busy(busy, 1'b0, "busy after load done");
        end
        loaded[row.core]   = 1'b1;
        exp_base[row.core] = row.base;
        for (int c = 0; c < CORES; c++) begin
            if (loaded[c])
                check_core(c);  // earlier cores must be untouched
        end
    endtask

    initial begin
        kick        = 1'b0;
        base_addr   = '0;
        target_core = '0;
        rd_sel      = SEL_INSN;
        rd_core     = '0;
        rd_addr     = '0;
        reset       = 1'b1;
        load_base   = '0;
        word_errs   = 0;
        busy_errs   = 0;
        cmd_errs    = 0;
        other_errs  = 0;
        foreach (loaded[c])
            loaded[c] = 1'b0;
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;
        #1 check_busy(busy, 1'b0, "busy after reset");
        foreach (table_rows[r])
            run_row(table_rows[r]);
        $display("errors: word %0d, busy %0d, cmd %0d, other %0d",
                 word_errs, busy_errs, cmd_errs, other_errs);
        if (word_errs + busy_errs + cmd_errs + other_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        repeat (NUM_ROWS * ROW_CYCLES + 8) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung",
                 NUM_ROWS * ROW_CYCLES + 8);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* program_loader_top.f */
design/avalon_pkg.sv
design/loader_pkg.sv
design/load_sequencer.sv
design/avalon_read_master.sv
design/line_unpacker.sv
design/core_mem_bank.sv
design/program_loader_top.sv
test/avalon_mem_model.sv
test/tb_program_loader.sv

/* Bender.yml */
package:
  name: program_loader

sources:
  - files:
      - design/avalon_pkg.sv
      - design/loader_pkg.sv
      - design/load_sequencer.sv
      - design/avalon_read_master.sv
      - design/line_unpacker.sv
      - design/core_mem_bank.sv
      - design/program_loader_top.sv
  - target: test
    files:
      - test/avalon_mem_model.sv
      - test/tb_program_loader.sv
